// ==== hdl/cpu_pkg.sv ====
// shared widths, opcodes, operation and state enums
// and the memory map of the byte bus
`default_nettype none

package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [4:0]  regnm_t;
    typedef logic [1:0]  mem_len_t;

    // size codes match funct3[1:0] of loads and stores
    localparam mem_len_t LEN_BYTE = 2'd0;
    localparam mem_len_t LEN_HALF = 2'd1;
    localparam mem_len_t LEN_WORD = 2'd2;

    // RV32I major opcodes
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    // uart byte out and program stop
    localparam addr_t  IO_BASE      = 32'h0003_0000;
    localparam addr_t  IO_HALT_ADDR = 32'h0003_0004;
    localparam addr_t  RESET_PC     = 32'h0000_0000;
    localparam regnm_t DBG_REG      = 5'd10;

    typedef enum logic [4:0] {
        OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU, OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND,
        OP_LUI, OP_AUIPC, OP_JAL, OP_JALR,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        OP_LOAD, OP_STORE, OP_NOP
    } alu_op_e;

    typedef enum logic [2:0] {
        S_FETCH, S_FETCH_WAIT, S_DECODE, S_EXECUTE, S_MEM, S_MEM_WAIT, S_WRITEBACK
    } seq_state_e;

endpackage

`default_nettype wire

// ==== hdl/mem_req_if.sv ====
// word-level memory request channel, sequencer to memory controller
`timescale 1ns/10ps
`default_nettype none

interface mem_req_if import cpu_pkg::*; ();

    logic     en;
    logic     ls;
    mem_len_t len;
    addr_t    addr;
    word_t    wdata;
    logic     done;
    // zero-extended to len
    word_t    rdata;

    modport master (output en, ls, len, addr, wdata, input done, rdata);
    modport slave  (input en, ls, len, addr, wdata, output done, rdata);

endinterface

`default_nettype wire

// ==== hdl/memctrl.sv ====
// memory controller that splits word/half/byte requests into byte cycles
`timescale 1ns/10ps
`default_nettype none

module memctrl import cpu_pkg::*; (
    input  logic       clk_in,
    input  logic       rst,
    input  logic       rdy_in,
    input  logic       io_buffer_full,
    input  logic [7:0] mem_din,
    output logic [7:0] mem_dout,
    output addr_t      mem_a,
    output logic       mem_wr,
    mem_req_if.slave   req
);

    logic       busy;
    logic       done_q;
    logic       wr_q;
    logic [1:0] cnt;
    logic [1:0] nxt;
    logic [1:0] last;
    logic       io_hold;
    logic       start;
    logic       step;
    logic       cap_en;
    logic [1:0] cap_idx;
    word_t      buf_q;

    always_comb begin
        case (req.len)
            LEN_BYTE: last = 2'd0;
            LEN_HALF: last = 2'd1;
            default:  last = 2'd3;
        endcase
    end

    // uart byte waits here until the buffer drains
    assign io_hold = wr_q && (mem_a >= IO_BASE) && io_buffer_full;
    assign start   = rdy_in && req.en && !busy && !done_q;
    assign step    = rdy_in && busy && !io_hold;
    assign nxt     = cnt + 2'd1;
    assign mem_wr  = wr_q && rdy_in && !io_hold;
    assign req.done = done_q;

    always_ff @(posedge clk_in) begin
        if (rst) begin
            busy   <= 1'b0;
            done_q <= 1'b0;
            wr_q   <= 1'b0;
            cnt    <= 2'd0;
            mem_a  <= '0;
        end else if (rdy_in) begin
            done_q <= 1'b0;
            if (start) begin
                busy  <= 1'b1;
                cnt   <= 2'd0;
                wr_q  <= req.ls;
                mem_a <= req.addr;
            end else if (step && cnt == last) begin
                busy   <= 1'b0;
                wr_q   <= 1'b0;
                done_q <= 1'b1;
            end else if (step) begin
                cnt   <= nxt;
                mem_a <= mem_a + 32'd1;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (start) begin
            mem_dout <= req.wdata[7:0];
        end else if (step && cnt != last) begin
            mem_dout <= req.wdata[8*nxt +: 8];
        end
    end

    // read data lags its address by one cycle even in a stall
    always_ff @(posedge clk_in) begin
        if (rst) begin
            cap_en <= 1'b0;
        end else begin
            cap_en <= rdy_in && busy && !wr_q;
        end
    end

    always_ff @(posedge clk_in) begin
        cap_idx <= cnt;
        if (cap_en) begin
            buf_q[8*cap_idx +: 8] <= mem_din;
        end
    end

    // last byte comes straight off the bus on the done cycle
    always_comb begin
        case (req.len)
            LEN_BYTE: req.rdata = {24'd0, mem_din};
            LEN_HALF: req.rdata = {16'd0, mem_din, buf_q[7:0]};
            default:  req.rdata = {mem_din, buf_q[23:0]};
        endcase
    end

    // a pending request keeps its fields until done
    assert property (@(posedge clk_in) disable iff (rst)
        req.en && !req.done |=> req.en && $stable(req.addr) && $stable(req.len)
            && $stable(req.ls) && $stable(req.wdata));

endmodule

`default_nettype wire

// ==== hdl/regfile.sv ====
// 32 x 32 register file, two read ports and one write port
`timescale 1ns/10ps
`default_nettype none

module regfile import cpu_pkg::*; (
    input  logic   clk_in,
    input  logic   rst,
    input  logic   rdy_in,
    input  regnm_t rs1,
    input  regnm_t rs2,
    output word_t  rs1_dt,
    output word_t  rs2_dt,
    input  logic   we,
    input  regnm_t rd,
    input  word_t  rd_dt,
    output word_t  dbg_dt
);

    word_t regs [32];

    always_ff @(posedge clk_in) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rdy_in && we && rd != '0) begin
            regs[rd] <= rd_dt;
        end
    end

    // x0 is never written so it reads zero
    assign rs1_dt = regs[rs1];
    assign rs2_dt = regs[rs2];
    assign dbg_dt = regs[DBG_REG];

endmodule

`default_nettype wire

// ==== hdl/decoder.sv ====
// instruction decoder: operation, register numbers, immediate
`timescale 1ns/10ps
`default_nettype none

module decoder import cpu_pkg::*; (
    input  word_t      inst,
    output alu_op_e    op,
    output regnm_t     rs1,
    output regnm_t     rs2,
    output regnm_t     rd,
    output word_t      imm,
    output logic [2:0] funct3,
    output logic       writes_rd
);

    logic [6:0] opcode;
    logic       wr;
    alu_op_e    alu_op;

    assign opcode    = inst[6:0];
    assign rd        = inst[11:7];
    assign funct3    = inst[14:12];
    assign rs1       = inst[19:15];
    assign rs2       = inst[24:20];
    assign writes_rd = wr && (rd != '0);

    // OP and OP-IMM share the funct3 map, only OP has sub
    always_comb begin
        case (funct3)
            3'b000:  alu_op = (opcode == OPC_OP && inst[30]) ? OP_SUB : OP_ADD;
            3'b001:  alu_op = OP_SLL;
            3'b010:  alu_op = OP_SLT;
            3'b011:  alu_op = OP_SLTU;
            3'b100:  alu_op = OP_XOR;
            3'b101:  alu_op = inst[30] ? OP_SRA : OP_SRL;
            3'b110:  alu_op = OP_OR;
            default: alu_op = OP_AND;
        endcase
    end

    always_comb begin
        op  = OP_NOP;
        wr  = 1'b0;
        imm = {{20{inst[31]}}, inst[31:20]};
        case (opcode)
            OPC_LUI, OPC_AUIPC: begin
                op  = (opcode == OPC_LUI) ? OP_LUI : OP_AUIPC;
                wr  = 1'b1;
                imm = {inst[31:12], 12'd0};
            end
            OPC_JAL: begin
                op  = OP_JAL;
                wr  = 1'b1;
                imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            OPC_BRANCH: begin
                imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
                case (funct3)
                    3'b000:  op = OP_BEQ;
                    3'b001:  op = OP_BNE;
                    3'b100:  op = OP_BLT;
                    3'b101:  op = OP_BGE;
                    3'b110:  op = OP_BLTU;
                    3'b111:  op = OP_BGEU;
                    default: op = OP_NOP;
                endcase
            end
            OPC_STORE: begin
                op  = OP_STORE;
                imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            end
            OPC_JALR: begin
                op = OP_JALR;
                wr = 1'b1;
            end
            OPC_LOAD: begin
                op = OP_LOAD;
                wr = 1'b1;
            end
            OPC_OPIMM, OPC_OP: begin
                op = alu_op;
                wr = 1'b1;
            end
            // unknown opcodes fall through as nop
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/execute.sv ====
// ALU, branch compare, jump target and link address
`timescale 1ns/10ps
`default_nettype none

module execute import cpu_pkg::*; (
    input  alu_op_e op,
    input  addr_t   pc,
    input  word_t   rs1_dt,
    input  word_t   rs2_dt,
    input  word_t   imm,
    output word_t   result,
    output logic    taken,
    output addr_t   target
);

    word_t link;
    word_t eff;

    assign link = pc + 32'd4;
    assign eff  = rs1_dt + imm;

    // rs2_dt carries the immediate for OP-IMM
    always_comb begin
        result = '0;
        taken  = 1'b0;
        target = pc + imm;
        case (op)
            OP_ADD:   result = rs1_dt + rs2_dt;
            OP_SUB:   result = rs1_dt - rs2_dt;
            OP_SLL:   result = rs1_dt << rs2_dt[4:0];
            OP_SLT:   result = {31'd0, $signed(rs1_dt) < $signed(rs2_dt)};
            OP_SLTU:  result = {31'd0, rs1_dt < rs2_dt};
            OP_XOR:   result = rs1_dt ^ rs2_dt;
            OP_SRL:   result = rs1_dt >> rs2_dt[4:0];
            OP_SRA:   result = $signed(rs1_dt) >>> rs2_dt[4:0];
            OP_OR:    result = rs1_dt | rs2_dt;
            OP_AND:   result = rs1_dt & rs2_dt;
            OP_LUI:   result = imm;
            OP_AUIPC: result = pc + imm;
            OP_JAL: begin
                result = link;
                taken  = 1'b1;
            end
            OP_JALR: begin
                result = link;
                taken  = 1'b1;
                target = {eff[31:1], 1'b0};
            end
            OP_BEQ:   taken = rs1_dt == rs2_dt;
            OP_BNE:   taken = rs1_dt != rs2_dt;
            OP_BLT:   taken = $signed(rs1_dt) < $signed(rs2_dt);
            OP_BGE:   taken = $signed(rs1_dt) >= $signed(rs2_dt);
            OP_BLTU:  taken = rs1_dt < rs2_dt;
            OP_BGEU:  taken = rs1_dt >= rs2_dt;
            // effective address
            OP_LOAD, OP_STORE: result = eff;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/sequencer.sv ====
// instruction sequencer with the pc, instruction register and the
// fetch / decode / execute / memory / writeback FSM
`timescale 1ns/10ps
`default_nettype none

module sequencer import cpu_pkg::*; (
    input  logic       clk_in,
    input  logic       rst,
    input  logic       rdy_in,
    mem_req_if.master  mem,
    output word_t      inst,
    input  alu_op_e    dec_op,
    input  regnm_t     dec_rd,
    input  word_t      dec_imm,
    input  logic [2:0] dec_funct3,
    input  logic       dec_writes_rd,
    output alu_op_e    ex_op,
    output addr_t      ex_pc,
    output word_t      ex_rs1_dt,
    output word_t      ex_rs2_dt,
    output word_t      ex_imm,
    input  word_t      ex_result,
    input  logic       ex_taken,
    input  addr_t      ex_target,
    input  word_t      rf_rs1_dt,
    input  word_t      rf_rs2_dt,
    output logic       rf_we,
    output regnm_t     rf_rd,
    output word_t      rf_rd_dt
);

    seq_state_e state;
    addr_t      pc;
    word_t      ir;
    word_t      rs1_q;
    word_t      rs2_q;
    word_t      imm_q;
    word_t      res_q;
    alu_op_e    op_q;
    regnm_t     rd_q;
    logic [2:0] funct3_q;
    logic       wrd_q;
    logic       in_mem;
    word_t      load_dt;

    assign inst      = ir;
    assign ex_op     = op_q;
    assign ex_pc     = pc;
    assign ex_rs1_dt = rs1_q;
    assign ex_rs2_dt = (ir[6:0] == OPC_OPIMM) ? imm_q : rs2_q;
    assign ex_imm    = imm_q;

    // request fields are stable for the whole wait state
    assign in_mem    = (state == S_MEM) || (state == S_MEM_WAIT);
    assign mem.en    = (state == S_FETCH_WAIT) || (state == S_MEM_WAIT);
    assign mem.ls    = in_mem && (op_q == OP_STORE);
    assign mem.len   = in_mem ? mem_len_t'(funct3_q[1:0]) : LEN_WORD;
    assign mem.addr  = in_mem ? res_q : pc;
    assign mem.wdata = rs2_q;

    assign rf_we    = (state == S_WRITEBACK) && wrd_q;
    assign rf_rd    = rd_q;
    assign rf_rd_dt = res_q;

    // lbu and lhu arrive zero-extended and lb and lh get their sign here
    always_comb begin
        case (funct3_q)
            3'b000:  load_dt = {{24{mem.rdata[7]}}, mem.rdata[7:0]};
            3'b001:  load_dt = {{16{mem.rdata[15]}}, mem.rdata[15:0]};
            default: load_dt = mem.rdata;
        endcase
    end

    always_ff @(posedge clk_in) begin
        if (rst) begin
            state <= S_FETCH;
            pc    <= RESET_PC;
            wrd_q <= 1'b0;
        end else if (rdy_in) begin
            case (state)
                S_FETCH:      state <= S_FETCH_WAIT;
                S_FETCH_WAIT: state <= mem.done ? S_DECODE : S_FETCH_WAIT;
                S_DECODE: begin
                    wrd_q <= dec_writes_rd;
                    state <= S_EXECUTE;
                end
                S_EXECUTE: begin
                    if (op_q == OP_LOAD || op_q == OP_STORE) begin
                        state <= S_MEM;
                    end else begin
                        state <= S_WRITEBACK;
                    end
                end
                S_MEM:        state <= S_MEM_WAIT;
                S_MEM_WAIT:   state <= mem.done ? S_WRITEBACK : S_MEM_WAIT;
                S_WRITEBACK: begin
                    // execute inputs are still held so taken is valid here
                    pc    <= ex_taken ? ex_target : pc + 32'd4;
                    state <= S_FETCH;
                end
                default:      state <= S_FETCH;
            endcase
        end
    end

    always_ff @(posedge clk_in) begin
        if (rdy_in) begin
            if (state == S_FETCH_WAIT && mem.done) begin
                ir <= mem.rdata;
            end
            if (state == S_DECODE) begin
                op_q     <= dec_op;
                rd_q     <= dec_rd;
                imm_q    <= dec_imm;
                funct3_q <= dec_funct3;
                rs1_q    <= rf_rs1_dt;
                rs2_q    <= rf_rs2_dt;
            end
            if (state == S_EXECUTE) begin
                res_q <= ex_result;
            end
            if (state == S_MEM_WAIT && mem.done && op_q == OP_LOAD) begin
                res_q <= load_dt;
            end
        end
    end

    // no done pulse outside the fetch and memory waits
    assert property (@(posedge clk_in) disable iff (rst)
        state inside {S_DECODE, S_EXECUTE, S_WRITEBACK} |-> !mem.done);

endmodule

`default_nettype wire

// ==== hdl/cpu.sv ====
// RV32I multi-cycle core on an 8-bit memory bus
`timescale 1ns/10ps
`default_nettype none

module cpu import cpu_pkg::*; (
    input  logic       clk_in,
    input  logic       rst,
    input  logic       rdy_in,
    input  logic [7:0] mem_din,
    output logic [7:0] mem_dout,
    output addr_t      mem_a,
    output logic       mem_wr,
    input  logic       io_buffer_full,
    output word_t      dbgreg_dout
);

    word_t      ir;
    alu_op_e    dec_op;
    regnm_t     dec_rs1;
    regnm_t     dec_rs2;
    regnm_t     dec_rd;
    word_t      dec_imm;
    logic [2:0] dec_funct3;
    logic       dec_writes_rd;
    alu_op_e    ex_op;
    addr_t      ex_pc;
    word_t      ex_rs1_dt;
    word_t      ex_rs2_dt;
    word_t      ex_imm;
    word_t      ex_result;
    logic       ex_taken;
    addr_t      ex_target;
    word_t      rf_rs1_dt;
    word_t      rf_rs2_dt;
    logic       rf_we;
    regnm_t     rf_rd;
    word_t      rf_rd_dt;

    mem_req_if mem_req ();

    memctrl memctrl_i (
        .clk_in, .rst, .rdy_in, .io_buffer_full,
        .mem_din, .mem_dout, .mem_a, .mem_wr,
        .req(mem_req.slave)
    );

    // register numbers go straight from the decoder to the read ports
    regfile regfile_i (
        .clk_in, .rst, .rdy_in,
        .rs1(dec_rs1), .rs2(dec_rs2), .rs1_dt(rf_rs1_dt), .rs2_dt(rf_rs2_dt),
        .we(rf_we), .rd(rf_rd), .rd_dt(rf_rd_dt), .dbg_dt(dbgreg_dout)
    );

    decoder decoder_i (
        .inst(ir), .op(dec_op), .rs1(dec_rs1), .rs2(dec_rs2), .rd(dec_rd),
        .imm(dec_imm), .funct3(dec_funct3), .writes_rd(dec_writes_rd)
    );

    execute execute_i (
        .op(ex_op), .pc(ex_pc), .rs1_dt(ex_rs1_dt), .rs2_dt(ex_rs2_dt), .imm(ex_imm),
        .result(ex_result), .taken(ex_taken), .target(ex_target)
    );

    sequencer sequencer_i (
        .clk_in, .rst, .rdy_in, .mem(mem_req.master), .inst(ir),
        .dec_op, .dec_rd, .dec_imm, .dec_funct3, .dec_writes_rd,
        .ex_op, .ex_pc, .ex_rs1_dt, .ex_rs2_dt, .ex_imm,
        .ex_result, .ex_taken, .ex_target,
        .rf_rs1_dt, .rf_rs2_dt, .rf_we, .rf_rd, .rf_rd_dt
    );

endmodule

`default_nettype wire

// ==== sim/tb_cpu.sv ====
// testbench for the RV32I core with a byte memory model, program image,
// random bus stalls and checking assertions
`timescale 1ns/10ps
`default_nettype none

module tb_cpu import cpu_pkg::*; ();

    logic       clk_in = 1'b0;
    logic       rst;
    logic       rdy_in;
    logic       io_buffer_full;
    logic [7:0] mem_din;
    logic [7:0] mem_dout;
    addr_t      mem_a;
    logic       mem_wr;
    word_t      dbgreg_dout;

    logic [7:0] mem [0:32'h1FFFF];
    logic [7:0] exp_q [$];
    logic [7:0] st [7];
    int         mismatches;
    int         failures;
    int         n_inst;
    int         n_logged;
    int         n_total;
    int         post_rst;
    logic       halted;
    logic       stall_on;
    logic       was_stalled;
    addr_t      stall_a;
    logic [31:0] rnd;
    addr_t      pc;
    word_t      chk;

    cpu cpu_i (
        .clk_in, .rst, .rdy_in, .mem_din, .mem_dout, .mem_a, .mem_wr,
        .io_buffer_full, .dbgreg_dout
    );

    always #4 clk_in = ~clk_in;

    function automatic logic [31:0] lcg(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic word_t enc_r(input logic [6:0] f7, input regnm_t rs2, input regnm_t rs1,
                                    input logic [2:0] f3, input regnm_t rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic word_t enc_i(input logic [11:0] imm, input regnm_t rs1,
                                    input logic [2:0] f3, input regnm_t rd,
                                    input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t enc_s(input logic [11:0] imm, input regnm_t rs2,
                                    input regnm_t rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
    endfunction

    function automatic word_t enc_b(input logic [12:0] imm, input regnm_t rs2,
                                    input regnm_t rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic word_t enc_u(input logic [19:0] imm, input regnm_t rd,
                                    input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic word_t enc_j(input logic [20:0] imm, input regnm_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    task automatic put(input word_t w);
        for (int i = 0; i < 4; i++) begin
            mem[pc[16:0] + 17'(i)] = w[8*i +: 8];
        end
        pc = pc + 32'd4;
    endtask

    task automatic put_addi(input regnm_t rd, input regnm_t rs1, input logic [11:0] imm);
        put(enc_i(imm, rs1, 3'd0, rd, OPC_OPIMM));
    endtask

    // store rs to the uart and expect b unless it is zero
    task automatic emit(input regnm_t rs, input logic [7:0] b);
        put(enc_s(12'd0, rs, 5'd5, 3'd0));
        if (b != 8'd0) begin
            exp_q.push_back(b);
        end
    endtask

    task automatic load_emit(input logic [2:0] f3, input logic [11:0] off,
                             input logic [11:0] sh, input logic [7:0] b);
        put(enc_i(off, 5'd6, f3, 5'd3, OPC_LOAD));
        put(enc_i(sh, 5'd3, 3'd5, 5'd3, OPC_OPIMM));
        emit(5'd3, b);
    endtask

    task automatic build_program();
        word_t      va;
        word_t      vb;
        word_t      vc;
        addr_t      pa;
        logic [2:0] f3;
        logic [5:0] jumps;
        va = 32'd100;
        vb = 32'hFFFF_FFF9;
        vc = 32'h1234_5678;
        // -7 against 100 jumps only for bne, blt and bgeu
        jumps = 6'b100110;
        pc = RESET_PC;
        put(enc_u(20'h00030, 5'd5, OPC_LUI));
        put_addi(5'd1, 5'd0, 12'd100);
        put_addi(5'd2, 5'd0, 12'hFF9);
        put_addi(5'd8, 5'd0, 12'h058);
        put_addi(5'd7, 5'd0, 12'd4);
        put(enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd3));
        emit(5'd3, 8'(va + vb));
        put(enc_r(7'h20, 5'd2, 5'd1, 3'd0, 5'd3));
        emit(5'd3, 8'(va - vb));
        // sra and srl of the same negative value
        put(enc_i(12'h419, 5'd2, 3'd5, 5'd3, OPC_OPIMM));
        emit(5'd3, 8'($signed(vb) >>> 25));
        put(enc_i(12'h019, 5'd2, 3'd5, 5'd3, OPC_OPIMM));
        emit(5'd3, 8'(vb >> 25));
        put(enc_r(7'h00, 5'd7, 5'd1, 3'd1, 5'd3));
        emit(5'd3, 8'(va << 4));
        put(enc_r(7'h00, 5'd1, 5'd2, 3'd2, 5'd3));
        emit(5'd3, 8'($signed(vb) < $signed(va)));
        put(enc_r(7'h00, 5'd1, 5'd2, 3'd3, 5'd3));
        put(enc_i(12'h030, 5'd3, 3'd6, 5'd3, OPC_OPIMM));
        emit(5'd3, 8'({31'd0, vb < va} | 32'h30));
        put(enc_r(7'h00, 5'd2, 5'd1, 3'd4, 5'd3));
        emit(5'd3, 8'(va ^ vb));
        put(enc_r(7'h00, 5'd2, 5'd1, 3'd7, 5'd3));
        emit(5'd3, 8'(va & vb));
        put(enc_r(7'h00, 5'd2, 5'd1, 3'd6, 5'd3));
        emit(5'd3, 8'(va | vb));
        put(enc_i(12'h00F, 5'd2, 3'd7, 5'd3, OPC_OPIMM));
        emit(5'd3, 8'(vb & 32'hF));
        put(enc_i(12'd3, 5'd1, 3'd1, 5'd3, OPC_OPIMM));
        emit(5'd3, 8'(va << 3));
        put(enc_u(20'h12345, 5'd4, OPC_LUI));
        put_addi(5'd4, 5'd4, 12'h678);
        put(enc_i(12'd8, 5'd4, 3'd5, 5'd3, OPC_OPIMM));
        emit(5'd3, 8'(vc >> 8));
        pa = pc;
        put(enc_u(20'd1, 5'd3, OPC_AUIPC));
        emit(5'd3, 8'(pa + 32'h1000));
        // data area at 0x400 written with every store size
        put_addi(5'd6, 5'd0, 12'h400);
        put(enc_s(12'd0, 5'd4, 5'd6, 3'd2));
        put(enc_s(12'd4, 5'd2, 5'd6, 3'd1));
        put(enc_s(12'd6, 5'd1, 5'd6, 3'd0));
        st = '{vc[7:0], vc[15:8], vc[23:16], vc[31:24], vb[7:0], vb[15:8], va[7:0]};
        load_emit(3'd0, 12'd3, 12'd0, vc[31:24]);
        load_emit(3'd0, 12'd4, 12'd24, 8'({{24{vb[7]}}, vb[7:0]} >> 24));
        load_emit(3'd4, 12'd4, 12'd4, 8'({24'd0, vb[7:0]} >> 4));
        load_emit(3'd1, 12'd4, 12'd16, 8'({{16{vb[15]}}, vb[15:0]} >> 16));
        load_emit(3'd5, 12'd4, 12'd12, 8'({16'd0, vb[15:0]} >> 12));
        load_emit(3'd2, 12'd0, 12'd16, 8'(vc >> 16));
        load_emit(3'd4, 12'd6, 12'd0, va[7:0]);
        // each branch may skip one marker store and then prints its number
        for (int k = 0; k < 6; k++) begin
            f3 = (k < 2) ? 3'(k) : 3'(k + 2);
            put(enc_b(13'd8, 5'd1, 5'd2, f3));
            put(enc_s(12'd0, 5'd8, 5'd5, 3'd0));
            if (!jumps[k]) begin
                exp_q.push_back(8'h58);
            end
            put_addi(5'd3, 5'd0, 12'(48 + k));
            emit(5'd3, 8'(48 + k));
        end
        pa = pc;
        put(enc_j(21'd8, 5'd9));
        put(enc_s(12'd0, 5'd8, 5'd5, 3'd0));
        emit(5'd9, 8'(pa + 32'd4));
        chk = (vc + vb) ^ (pa + 32'd4);
        pa = pc;
        put(enc_u(20'd0, 5'd12, OPC_AUIPC));
        put(enc_i(12'd13, 5'd12, 3'd0, 5'd11, OPC_JALR));
        put(enc_s(12'd0, 5'd8, 5'd5, 3'd0));
        emit(5'd11, 8'(pa + 32'd8));
        put(enc_r(7'h00, 5'd2, 5'd4, 3'd0, 5'd10));
        put(enc_r(7'h00, 5'd9, 5'd10, 3'd4, 5'd10));
        put(enc_s(12'd4, 5'd8, 5'd5, 3'd0));
        put(enc_j(21'd0, 5'd0));
        n_total = exp_q.size();
        n_inst  = int'(pc >> 2);
    endtask

    task automatic log_byte(input logic [7:0] b);
        n_logged++;
        if (n_logged >= n_total / 2) begin
            stall_on = 1'b1;
        end
        if (exp_q.size() == 0) begin
            $display("unexpected extra output byte %h at %0t", b, $time);
            failures++;
        end else begin
            assert (b == exp_q[0]) else begin
                $display("Mismatch at %0t: output byte %h, expected %h", $time, b, exp_q[0]);
                mismatches++;
            end
            void'(exp_q.pop_front());
        end
    endtask

    task automatic halt_checks();
        assert (dbgreg_dout == chk) else begin
            $display("Mismatch at %0t: a0 is %h, expected %h", $time, dbgreg_dout, chk);
            mismatches++;
        end
        assert (exp_q.size() == 0) else begin
            $display("program stopped with %0d output bytes missing", exp_q.size());
            failures++;
        end
        for (int i = 0; i < 7; i++) begin
            assert (mem[17'h400 + 17'(i)] == st[i]) else begin
                $display("Mismatch at %0t: stored byte %0d is %h, expected %h",
                         $time, i, mem[17'h400 + 17'(i)], st[i]);
                mismatches++;
            end
        end
        halted = 1'b1;
    endtask

    // byte memory with read data one cycle behind the address
    always @(posedge clk_in) begin
        mem_din <= mem[mem_a[16:0]];
        if (mem_wr) begin
            if (mem_a < IO_BASE) begin
                mem[mem_a[16:0]] = mem_dout;
            end else if (mem_a == IO_BASE && mem_dout != 8'd0) begin
                log_byte(mem_dout);
            end else if (mem_a == IO_HALT_ADDR) begin
                halt_checks();
            end
        end
    end

    always @(posedge clk_in) begin
        if (!rst) begin
            if (post_rst < 3) begin
                assert (!mem_wr && mem_a == RESET_PC) else begin
                    $display("bus is not reading the reset pc after reset");
                    failures++;
                end
                post_rst++;
            end
            if (was_stalled) begin
                assert (mem_a == stall_a) else begin
                    $display("memory address moved during a stall at %0t", $time);
                    failures++;
                end
            end
            if (!rdy_in) begin
                assert (!mem_wr) else begin
                    $display("write issued while rdy_in is low at %0t", $time);
                    failures++;
                end
            end
            if (mem_wr && mem_a >= IO_BASE) begin
                assert (!io_buffer_full) else begin
                    $display("I/O write while io_buffer_full is high at %0t", $time);
                    failures++;
                end
            end
            was_stalled = !rdy_in;
            stall_a     = mem_a;
        end
    end

    // random stalls once half the output has been seen
    always @(negedge clk_in) begin
        if (stall_on && !halted) begin
            rnd = lcg(rnd);
            rdy_in = rnd[31:30] != 2'b00;
            io_buffer_full = rnd[29:28] == 2'b11;
        end
    end

    initial begin
        wait (n_inst != 0);
        #(n_inst * 40 * 20 * 8);
        $display("timeout: the program never reached the halt write");
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        rst = 1'b1;
        rdy_in = 1'b1;
        io_buffer_full = 1'b0;
        mem_din <= 8'd0;
        rnd = 32'hc4e10a32;
        mismatches = 0;
        failures = 0;
        n_logged = 0;
        post_rst = 0;
        halted = 1'b0;
        stall_on = 1'b0;
        was_stalled = 1'b0;
        stall_a = '0;
        for (int i = 0; i < 32'h20000; i++) begin
            mem[i] = 8'(i ^ (i >> 8) ^ (i >> 16));
        end
        build_program();
        repeat (4) @(posedge clk_in);
        @(negedge clk_in);
        rst = 1'b0;
        wait (halted);
        @(negedge clk_in);
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== cpu.f ====
hdl/cpu_pkg.sv
hdl/mem_req_if.sv
hdl/memctrl.sv
hdl/regfile.sv
hdl/decoder.sv
hdl/execute.sv
hdl/sequencer.sv
hdl/cpu.sv
sim/tb_cpu.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= tb_cpu
FILELIST  ?= cpu.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "STATUS: PASS"

clean:
	rm -rf obj_dir
